//--- Makefile
# Verilator build and run of the execute stage testbench

SIM = obj_dir/Vtb_exec

.PHONY: run clean

$(SIM): files.f $(wildcard hdl/*.sv verif/*.sv)
	verilator --binary --timing --assert --top-module tb_exec -f files.f -Mdir obj_dir

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/exec_mul.sv
hdl/exec_pipe_reg.sv
hdl/exec_stage.sv
verif/tb_exec.sv

//--- hdl/exec_alu.sv
/*
 * Integer ALU of the execute stage. Purely combinational.
 * Also exposes the raw sum and compare flags used for addresses and branches.
 */
`timescale 1ns/1ns

module exec_alu (
    input  logic [exec_pkg::UOP_W-1:0] i_uop,    // Micro-op code
    input  logic [exec_pkg::XLEN-1:0]  i_lhs,    // Left operand
    input  logic [exec_pkg::XLEN-1:0]  i_rhs,    // Right operand
    output logic [exec_pkg::XLEN-1:0]  o_result, // Selected ALU result
    output logic [exec_pkg::XLEN-1:0]  o_sum,    // Raw lhs + rhs
    output logic                       o_eq,     // lhs == rhs
    output logic                       o_lt,     // Signed lhs < rhs
    output logic                       o_ltu     // Unsigned lhs < rhs
);

import exec_pkg::*;

localparam int SHW = $clog2(XLEN);               // Shift amount width

logic [XLEN:0]   diff;                           // Borrow out in the MSB
logic [SHW-1:0]  shamt;                          // Low bits of rhs only
logic [XLEN-1:0] shl;                            // Left shift
logic [XLEN-1:0] shr;                            // Right shift, logical or arith
logic            sign_diff;                      // Operand signs differ

// --------------------
// Adder and compares

assign o_sum     = i_lhs + i_rhs;                // Shared with LSU and jalr
assign diff      = {1'b0, i_lhs} - {1'b0, i_rhs};
assign o_eq      = i_lhs == i_rhs;
assign o_ltu     = diff[XLEN];                   // Borrow means lhs < rhs

// Signs differ: the negative side is smaller, no overflow check needed
assign sign_diff = i_lhs[XLEN-1] ^ i_rhs[XLEN-1];
assign o_lt      = sign_diff ? i_lhs[XLEN-1] : diff[XLEN-1];

// --------------------
// Shifter

assign shamt = i_rhs[SHW-1:0];
assign shl   = i_lhs << shamt;

always_comb begin
    if (i_uop == ALU_SRA) begin
        shr = $unsigned($signed(i_lhs) >>> shamt); // Sign fill
    end else begin
        shr = i_lhs >> shamt;                      // Zero fill
    end
end

// --------------------
// Result select

always_comb begin
    case (i_uop)
        ALU_ADD:  o_result = o_sum;
        ALU_SUB:  o_result = diff[XLEN-1:0];
        ALU_XOR:  o_result = i_lhs ^ i_rhs;
        ALU_OR:   o_result = i_lhs | i_rhs;
        ALU_AND:  o_result = i_lhs & i_rhs;
        ALU_SLL:  o_result = shl;
        ALU_SRL:  o_result = shr;
        ALU_SRA:  o_result = shr;
        ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, o_lt};
        ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_ltu};
        default:  o_result = '0;                 // Keeps the forward OR clean
    endcase
end

endmodule

//--- hdl/exec_branch.sv
/*
 * Branch resolver. Turns the ALU compare flags into a taken/not-taken
 * micro-op and produces the halfword-aligned jump target.
 */
`timescale 1ns/1ns

module exec_branch (
    input  logic [exec_pkg::UOP_W-1:0] i_uop,    // Branch micro-op
    input  logic                       i_eq,     // From ALU compare
    input  logic                       i_lt,
    input  logic                       i_ltu,
    input  logic [exec_pkg::XLEN-1:0]  i_sum,    // rs1 + imm for jalr
    input  logic [exec_pkg::XLEN-1:0]  i_target, // pc-relative target from decode
    output logic [exec_pkg::UOP_W-1:0] o_uop,    // Resolved micro-op
    output logic [exec_pkg::XLEN-1:0]  o_target  // Jump or branch target
);

import exec_pkg::*;

logic [5:0]      cond;                           // beq bne blt bge bltu bgeu
logic            is_cond;                        // From encoding range
logic            taken;
logic [XLEN-1:0] raw_target;

// --------------------
// Condition decode

always_comb begin
    cond[0] = i_uop == CFU_BEQ;
    cond[1] = i_uop == CFU_BNE;
    cond[2] = i_uop == CFU_BLT;
    cond[3] = i_uop == CFU_BGE;
    cond[4] = i_uop == CFU_BLTU;
    cond[5] = i_uop == CFU_BGEU;
    is_cond = (i_uop[4:3] == 2'b10) && (i_uop[2:1] != 2'b11); // 0x10..0x15
    taken   = (cond[0] &&  i_eq ) ||
              (cond[1] && !i_eq ) ||
              (cond[2] &&  i_lt ) ||
              (cond[3] && !i_lt ) ||
              (cond[4] &&  i_ltu) ||
              (cond[5] && !i_ltu);
    // Range decode and per-code decode must agree
    if (is_cond) begin
        assert ($onehot(cond))
            else $error("branch decode mismatch for uop %h", i_uop);
    end
end

// --------------------
// Outputs

assign o_uop      = is_cond ? (taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_uop;
assign raw_target = (i_uop == CFU_JALR) ? i_sum : i_target;
assign o_target   = {raw_target[XLEN-1:1], 1'b0}; // Bit 0 always cleared

endmodule

//--- hdl/exec_mul.sv
/*
 * Iterative shift-add multiplier for mul, mulh, mulhu and mulhsu.
 * Consumes MUL_STEP_BITS multiplier bits per cycle and then holds o_ready
 * until the stage clears it on progress or flush.
 */
`timescale 1ns/1ns

module exec_mul #(
    parameter int MUL_STEP_BITS = 2              // 1, 2 or 4
) (
    input  logic                       g_clk,
    input  logic                       g_resetn,
    input  logic                       i_valid,  // Multiply op present
    input  logic                       i_clear,  // Progress or flush
    input  logic [exec_pkg::UOP_W-1:0] i_uop,
    input  logic [exec_pkg::XLEN-1:0]  i_rs1,
    input  logic [exec_pkg::XLEN-1:0]  i_rs2,
    output logic                       o_ready,  // Result valid
    output logic [exec_pkg::XLEN-1:0]  o_result
);

import exec_pkg::*;

localparam int STEPS = XLEN / MUL_STEP_BITS;     // Run cycles
localparam int CNT_W = $clog2(STEPS);

typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state_t;

state_t            state;
logic [CNT_W-1:0]  count;                        // Step index
logic              last_step;
logic              rs1_signed;
logic              neg_top;                      // rs2 MSB has negative weight
logic [2*XLEN-1:0] mcand;                        // Shifts left each step
logic [XLEN-1:0]   mplier;                       // Shifts right each step
logic [2*XLEN-1:0] acc;                          // Running product
logic [2*XLEN-1:0] pp;                           // Partial product this step

assign last_step  = count == CNT_W'(STEPS - 1);
assign rs1_signed = (i_uop == MUL_MULH) || (i_uop == MUL_MULHSU);

// --------------------
// Partial product

always_comb begin
    pp = '0;
    for (int i = 0; i < MUL_STEP_BITS; i++) begin
        if (mplier[i]) begin
            if (neg_top && last_step && (i == MUL_STEP_BITS - 1)) begin
                pp = pp - (mcand << i);          // Signed rs2 sign bit
            end else begin
                pp = pp + (mcand << i);
            end
        end
    end
end

// --------------------
// Control

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        state <= ST_IDLE;
        count <= '0;
    end else if (i_clear) begin
        state <= ST_IDLE;                        // Result taken or aborted
        count <= '0;
    end else begin
        case (state)
            ST_IDLE: if (i_valid) state <= ST_RUN;
            ST_RUN: begin
                count <= count + 1'b1;
                if (last_step) state <= ST_DONE;
            end
            default: state <= state;             // Hold until cleared
        endcase
    end
end

// --------------------
// Datapath

always_ff @(posedge g_clk) begin
    if (state == ST_IDLE && i_valid) begin
        mcand   <= {{XLEN{rs1_signed & i_rs1[XLEN-1]}}, i_rs1}; // Extend rs1
        mplier  <= i_rs2;
        neg_top <= i_uop == MUL_MULH;
        acc     <= '0;
    end else if (state == ST_RUN) begin
        acc    <= acc + pp;
        mcand  <= mcand << MUL_STEP_BITS;
        mplier <= mplier >> MUL_STEP_BITS;
    end
end

assign o_ready  = state == ST_DONE;
assign o_result = (i_uop == MUL_MUL) ? acc[XLEN-1:0] : acc[2*XLEN-1:XLEN];

// --------------------
// Checks

// Ready rises exactly one full run after a start from idle
assert property (@(posedge g_clk) disable iff (!g_resetn)
    $rose(o_ready) |-> $past(state == ST_IDLE && i_valid && !i_clear, STEPS + 1));

// Decode holds the operands from start until cleared
assert property (@(posedge g_clk) disable iff (!g_resetn)
    (i_valid || state != ST_IDLE) && !i_clear |=>
        $stable(i_rs1) && $stable(i_rs2) && $stable(i_uop));

endmodule

//--- hdl/exec_pipe_reg.sv
/*
 * Execute-to-writeback pipeline register. One entry, holds while
 * writeback is busy, flush drops the held entry.
 */
`timescale 1ns/1ns

module exec_pipe_reg (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  exec_pkg::s3_op_t i_data,             // Record from execute
    input  logic             i_valid,            // Load request
    input  logic             i_flush,            // Drop held entry
    input  logic             i_busy,             // Writeback stalled
    output exec_pkg::s3_op_t o_data,             // Record to writeback
    output logic             o_valid,
    output logic             o_busy              // Cannot take a new record
);

import exec_pkg::*;

s3_op_t data_q;                                  // Held record
logic   valid_q;

assign o_busy  = valid_q && i_busy;              // Full and not draining
assign o_data  = data_q;
assign o_valid = valid_q;

// --------------------
// Valid bit

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        valid_q <= 1'b0;
    end else if (i_flush) begin
        valid_q <= 1'b0;
    end else if (!o_busy) begin
        valid_q <= i_valid;                      // Drain or refill
    end
end

// --------------------
// Payload

always_ff @(posedge g_clk) begin
    if (i_valid && !o_busy) begin
        data_q <= i_data;
    end
end

// A load request while full would be lost
assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_valid |-> !o_busy);

endmodule

//--- hdl/exec_pkg.sv
/*
 * Widths, micro-op codes, unit select and stage records for the execute stage.
 * RTL modules import it inside their bodies. Ports use scoped names.
 */
package exec_pkg;

// --------------------
// Widths
localparam int XLEN  = 32;                       // Data path
localparam int REG_W = 5;                        // Register address
localparam int UOP_W = 5;                        // Micro-op code

// --------------------
// Micro-op codes, unique across all units
localparam logic [UOP_W-1:0] ALU_ADD       = 5'h00;
localparam logic [UOP_W-1:0] ALU_SUB       = 5'h01;
localparam logic [UOP_W-1:0] ALU_XOR       = 5'h02;
localparam logic [UOP_W-1:0] ALU_OR        = 5'h03;
localparam logic [UOP_W-1:0] ALU_AND       = 5'h04;
localparam logic [UOP_W-1:0] ALU_SLL       = 5'h05;
localparam logic [UOP_W-1:0] ALU_SRL       = 5'h06;
localparam logic [UOP_W-1:0] ALU_SRA       = 5'h07;
localparam logic [UOP_W-1:0] ALU_SLT       = 5'h08;
localparam logic [UOP_W-1:0] ALU_SLTU      = 5'h09;

localparam logic [UOP_W-1:0] MUL_MUL       = 5'h0c; // Low half
localparam logic [UOP_W-1:0] MUL_MULH      = 5'h0d; // High, signed x signed
localparam logic [UOP_W-1:0] MUL_MULHU     = 5'h0e; // High, unsigned x unsigned
localparam logic [UOP_W-1:0] MUL_MULHSU    = 5'h0f; // High, signed x unsigned

// Conditional branches occupy 0x10..0x15
localparam logic [UOP_W-1:0] CFU_BEQ       = 5'h10;
localparam logic [UOP_W-1:0] CFU_BNE       = 5'h11;
localparam logic [UOP_W-1:0] CFU_BLT       = 5'h12;
localparam logic [UOP_W-1:0] CFU_BGE       = 5'h13;
localparam logic [UOP_W-1:0] CFU_BLTU      = 5'h14;
localparam logic [UOP_W-1:0] CFU_BGEU      = 5'h15;
localparam logic [UOP_W-1:0] CFU_JAL       = 5'h16;
localparam logic [UOP_W-1:0] CFU_JALR      = 5'h17;
localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'h18; // Resolved branch outcomes
localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'h19;

localparam logic [UOP_W-1:0] LSU_LOAD      = 5'h1a;
localparam logic [UOP_W-1:0] LSU_STORE     = 5'h1b;

// --------------------
// Stage records

// One-hot functional unit select, alu in the MSB
typedef struct packed {
    logic alu;
    logic mul;
    logic lsu;
    logic cfu;
    logic csr;
} fu_t;

// Decoded instruction from decode
typedef struct packed {
    logic [REG_W-1:0] rd;                        // Destination register
    logic [XLEN-1:0]  opr_a;                     // rs1 or pc
    logic [XLEN-1:0]  opr_b;                     // rs2 or immediate
    logic [XLEN-1:0]  opr_c;                     // Store data, csr data, branch target
    logic [UOP_W-1:0] uop;
    fu_t              fu;
    logic             trap;                      // Trap raised earlier
    logic [1:0]       size;                      // Access or instruction size
    logic [31:0]      instr;                     // Raw instruction word
} s2_op_t;

// Executed instruction toward writeback
typedef struct packed {
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  opr_a;                     // Result, address or target
    logic [XLEN-1:0]  opr_b;                     // Store/csr data or trap cause
    logic [UOP_W-1:0] uop;
    fu_t              fu;
    logic             trap;
    logic [1:0]       size;
    logic [31:0]      instr;
} s3_op_t;

// Bypass info back to decode
typedef struct packed {
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  wdata;
    logic             load;                      // Result not known yet
    logic             csr;                       // Result not known yet
} fwd_t;

endpackage

//--- hdl/exec_stage.sv
/*
 * Execute stage top. Runs one decoded instruction through ALU, branch,
 * multiplier, LSU address or CSR pass-through, registers the result for
 * writeback and returns bypass info to decode.
 */
`timescale 1ns/1ns

module exec_stage #(
    parameter int MUL_STEP_BITS = 2              // Multiplier bits per cycle
) (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  exec_pkg::s2_op_t i_s2_op,            // From decode
    input  logic             i_s2_valid,
    output logic             o_s2_busy,          // Stall decode
    input  logic             i_flush,            // One-cycle pulse
    output exec_pkg::fwd_t   o_fwd,              // Bypass to decode
    output exec_pkg::s3_op_t o_s3_op,            // To writeback
    output logic             o_s3_valid,
    input  logic             i_s3_busy
);

import exec_pkg::*;

fu_t             fu;                             // One-hot unit select
logic            pipe_progress;                  // Accepting edge this cycle
logic            p_busy;                         // Pipeline register full
logic [XLEN-1:0] alu_result;
logic [XLEN-1:0] alu_sum;
logic            alu_eq;
logic            alu_lt;
logic            alu_ltu;
logic [UOP_W-1:0] br_uop;
logic [XLEN-1:0] br_target;
logic            mul_valid;
logic            mul_clear;
logic            mul_ready;
logic [XLEN-1:0] mul_result;
s3_op_t          n_s3;                           // Next writeback record

assign fu            = i_s2_op.fu;
assign pipe_progress = i_s2_valid && !o_s2_busy;

// --------------------
// Functional units

exec_alu i_alu (
    .i_uop    (i_s2_op.uop  ),
    .i_lhs    (i_s2_op.opr_a),
    .i_rhs    (i_s2_op.opr_b),
    .o_result (alu_result   ),
    .o_sum    (alu_sum      ),
    .o_eq     (alu_eq       ),
    .o_lt     (alu_lt       ),
    .o_ltu    (alu_ltu      )
);

exec_branch i_branch (
    .i_uop    (i_s2_op.uop  ),
    .i_eq     (alu_eq       ),
    .i_lt     (alu_lt       ),
    .i_ltu    (alu_ltu      ),
    .i_sum    (alu_sum      ),                   // jalr target
    .i_target (i_s2_op.opr_c),                   // pc-relative target
    .o_uop    (br_uop       ),
    .o_target (br_target    )
);

assign mul_valid = i_s2_valid && fu.mul;
assign mul_clear = pipe_progress || i_flush;     // Result taken or aborted

exec_mul #(
    .MUL_STEP_BITS (MUL_STEP_BITS)
) i_mul (
    .g_clk    (g_clk        ),
    .g_resetn (g_resetn     ),
    .i_valid  (mul_valid    ),
    .i_clear  (mul_clear    ),
    .i_uop    (i_s2_op.uop  ),
    .i_rs1    (i_s2_op.opr_a),
    .i_rs2    (i_s2_op.opr_b),
    .o_ready  (mul_ready    ),
    .o_result (mul_result   )
);

// --------------------
// Result merge

always_comb begin
    n_s3.rd    = i_s2_op.rd;
    n_s3.opr_a = ({XLEN{fu.alu}} & alu_result   ) |
                 ({XLEN{fu.mul}} & mul_result   ) |
                 ({XLEN{fu.lsu}} & alu_sum      ) |  // Effective address
                 ({XLEN{fu.cfu}} & br_target    ) |
                 ({XLEN{fu.csr}} & i_s2_op.opr_a);
    if (i_s2_op.trap) begin
        n_s3.opr_b = {{(XLEN-REG_W){1'b0}}, i_s2_op.rd}; // Cause rides in rd
    end else if (fu.lsu || fu.csr) begin
        n_s3.opr_b = i_s2_op.opr_c;              // Store or csr write data
    end else begin
        n_s3.opr_b = '0;
    end
    n_s3.uop   = fu.cfu ? br_uop : i_s2_op.uop;
    n_s3.fu    = fu;
    n_s3.trap  = i_s2_op.trap;
    n_s3.size  = i_s2_op.size;
    n_s3.instr = i_s2_op.instr;
end

// --------------------
// Stall and bypass

assign o_s2_busy   = p_busy || (mul_valid && !mul_ready);
assign o_fwd.rd    = i_s2_op.rd;
assign o_fwd.wdata = fu.mul ? mul_result : alu_result;
assign o_fwd.load  = fu.lsu && (i_s2_op.uop == LSU_LOAD);
assign o_fwd.csr   = fu.csr;

exec_pipe_reg i_pipe_reg (
    .g_clk    (g_clk        ),
    .g_resetn (g_resetn     ),
    .i_data   (n_s3         ),
    .i_valid  (pipe_progress),
    .i_flush  (i_flush      ),
    .i_busy   (i_s3_busy    ),
    .o_data   (o_s3_op      ),
    .o_valid  (o_s3_valid   ),
    .o_busy   (p_busy       )
);

// Unit merge relies on decode sending a one-hot select
assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_s2_valid |-> $onehot(i_s2_op.fu));

endmodule

//--- verif/exec_stim.txt
# fu uop rd opr_a opr_b opr_c trap flush exp_uop exp_opr_a exp_opr_b, all hex
# fu: 10 alu, 08 mul, 04 lsu, 02 cfu, 01 csr; flush 1 aborts the op mid-run
10 00 01 00000005 00000007 00000000 0 0 00 0000000c 00000000
10 01 03 00000003 00000005 00000000 0 0 01 fffffffe 00000000
10 02 04 f0f0f0f0 ff00ff00 00000000 0 0 02 0ff00ff0 00000000
10 03 05 f0f0f0f0 0f0f0000 00000000 0 0 03 fffff0f0 00000000
10 04 06 f0f0f0f0 ff00ff00 00000000 0 0 04 f000f000 00000000
10 05 07 00000001 0000001f 00000000 0 0 05 80000000 00000000
10 06 09 80000000 00000004 00000000 0 0 06 08000000 00000000
10 07 0a 80000000 00000004 00000000 0 0 07 f8000000 00000000
10 08 0c ffffffff 00000001 00000000 0 0 08 00000001 00000000
10 09 0d ffffffff 00000001 00000000 0 0 09 00000000 00000000
02 10 0f 00000005 00000005 00001000 0 0 18 00001000 00000000
02 10 10 00000005 00000006 00001002 0 0 19 00001002 00000000
02 11 11 00000005 00000006 00002001 0 0 18 00002000 00000000
02 12 12 ffffffff 00000001 00003000 0 0 18 00003000 00000000
02 13 13 ffffffff 00000001 00003004 0 0 19 00003004 00000000
02 14 14 ffffffff 00000001 00004000 0 0 19 00004000 00000000
02 15 15 ffffffff 00000001 00004008 0 0 18 00004008 00000000
02 16 16 00000100 00000004 00005003 0 0 16 00005002 00000000
02 17 17 00006000 00000011 00000000 0 0 17 00006010 00000000
04 1a 18 00001000 00000010 0000abcd 0 0 1a 00001010 0000abcd
04 1b 00 00002000 fffffffc cafef00d 0 0 1b 00001ffc cafef00d
01 00 19 12345678 00000300 87654321 0 0 00 12345678 87654321
10 00 1c 00000001 00000002 00000000 1 0 00 00000003 0000001c
01 00 0b 0000aaaa 00000000 ffffffff 1 0 00 0000aaaa 0000000b
08 0c 01 00000007 00000006 00000000 0 0 0c 0000002a 00000000
08 0d 03 ffffffff 00000002 00000000 0 0 0d ffffffff 00000000
08 0d 04 80000000 80000000 00000000 0 0 0d 40000000 00000000
08 0e 05 ffffffff ffffffff 00000000 0 0 0e fffffffe 00000000
08 0f 07 ffffffff ffffffff 00000000 0 0 0f ffffffff 00000000
08 0f 08 00000002 80000000 00000000 0 0 0f 00000001 00000000
08 0c 09 00000003 00000003 00000000 0 1 00 00000000 00000000
10 00 0a 00000010 00000020 00000000 0 0 00 00000030 00000000
08 0c 0b 00000009 00000009 00000000 0 0 0c 00000051 00000000

//--- verif/tb_exec.sv
/*
 * Self-checking testbench for the execute stage. Reads instructions and
 * expected writeback records from the stim file, offers them as decode would,
 * stalls writeback at random and checks every result in order.
 */
`timescale 1ns/1ns

module tb_exec;

import exec_pkg::*;

localparam int PERIOD    = 40;                   // ns
localparam int RESET_CYC = 10;
localparam int LINE_CYC  = 200;                  // Timeout budget per line

// Expected writeback record
typedef struct packed {
    logic [REG_W-1:0] rd;
    logic [UOP_W-1:0] uop;
    logic [XLEN-1:0]  opr_a;
    logic [XLEN-1:0]  opr_b;
    fu_t              fu;
    logic             trap;
    logic [1:0]       size;
    logic [31:0]      tag;                       // Line number, rides in instr
} exp_t;

logic   g_clk;
logic   g_resetn;
s2_op_t i_s2_op;
logic   i_s2_valid;
logic   o_s2_busy;
logic   i_flush;
fwd_t   o_fwd;
s3_op_t o_s3_op;
logic   o_s3_valid;
logic   i_s3_busy;

s2_op_t ops[$];                                  // Stimulus lines
exp_t   exps[$];
bit     flushes[$];
exp_t   exp_q[$];                                // Accepted, result pending
int     checks;
int     value_errors;
int     other_errors;
int     cycles;
int     cycle_limit;
bit     flush_seen;                              // Flush on the last edge
bit     hold_busy;                               // Writeback stalled over a flush

exec_stage #(
    .MUL_STEP_BITS (2)
) i_dut (
    .g_clk      (g_clk     ),
    .g_resetn   (g_resetn  ),
    .i_s2_op    (i_s2_op   ),
    .i_s2_valid (i_s2_valid),
    .o_s2_busy  (o_s2_busy ),
    .i_flush    (i_flush   ),
    .o_fwd      (o_fwd     ),
    .o_s3_op    (o_s3_op   ),
    .o_s3_valid (o_s3_valid),
    .i_s3_busy  (i_s3_busy )
);

// --------------------
// Clock, back-pressure, timeout

initial begin
    g_clk = 1'b0;
    forever #(PERIOD/2) g_clk = ~g_clk;
end

initial begin
    i_s3_busy = 1'b0;
    void'($urandom(44));                         // Fixed seed
    forever begin
        @(negedge g_clk);
        i_s3_busy = g_resetn && (($urandom % 3 == 0) || hold_busy); // About one in three
    end
end

always @(posedge g_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
        other_errors++;
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        finish_run();
    end
end

// --------------------
// Reporting

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    value_errors++;
    $display("** Error: %s = %h, expected %h", name, got, want);
endtask

task automatic finish_run();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
endtask

// Bypass info is valid in the cycle the op is offered
task automatic check_fwd(input s2_op_t op, input exp_t e);
    logic want_load;
    want_load = op.fu.lsu && (op.uop == LSU_LOAD);
    assert (o_fwd.rd == op.rd)
        else report_mismatch("o_fwd.rd", 32'(o_fwd.rd), 32'(op.rd));
    assert (o_fwd.load == want_load)
        else report_mismatch("o_fwd.load", 32'(o_fwd.load), 32'(want_load));
    assert (o_fwd.csr == op.fu.csr)
        else report_mismatch("o_fwd.csr", 32'(o_fwd.csr), 32'(op.fu.csr));
    if (op.fu.alu) begin
        assert (o_fwd.wdata == e.opr_a)
            else report_mismatch("o_fwd.wdata", o_fwd.wdata, e.opr_a);
    end
endtask

task automatic check_result();
    exp_t e;
    if (exp_q.size() == 0) begin
        other_errors++;
        $display("result delivered with no instruction outstanding");
    end else begin
        e = exp_q.pop_front();
        checks++;
        assert (o_s3_op.instr == e.tag)
            else report_mismatch("o_s3_op.instr", o_s3_op.instr, e.tag);
        assert (o_s3_op.rd == e.rd)
            else report_mismatch("o_s3_op.rd", 32'(o_s3_op.rd), 32'(e.rd));
        assert (o_s3_op.uop == e.uop)
            else report_mismatch("o_s3_op.uop", 32'(o_s3_op.uop), 32'(e.uop));
        assert (o_s3_op.opr_a == e.opr_a)
            else report_mismatch("o_s3_op.opr_a", o_s3_op.opr_a, e.opr_a);
        assert (o_s3_op.opr_b == e.opr_b)
            else report_mismatch("o_s3_op.opr_b", o_s3_op.opr_b, e.opr_b);
        assert (o_s3_op.fu == e.fu)
            else report_mismatch("o_s3_op.fu", {27'd0, o_s3_op.fu}, {27'd0, e.fu});
        assert (o_s3_op.trap == e.trap)
            else report_mismatch("o_s3_op.trap", 32'(o_s3_op.trap), 32'(e.trap));
        assert (o_s3_op.size == e.size)
            else report_mismatch("o_s3_op.size", 32'(o_s3_op.size), 32'(e.size));
    end
endtask

// --------------------
// Driver

// Hold the op until the stage takes it
task automatic send_op(input s2_op_t op, input exp_t e, input bit stall_after);
    i_s2_op    = op;
    i_s2_valid = 1'b1;
    #(PERIOD/4);
    check_fwd(op, e);
    while (o_s2_busy) begin
        @(negedge g_clk);
        #(PERIOD/4);
    end
    if (op.fu.mul) begin
        assert (o_fwd.wdata == e.opr_a)          // Product bypassed at accept
            else report_mismatch("o_fwd.wdata", o_fwd.wdata, e.opr_a);
    end
    hold_busy = stall_after;                     // Keep this record for the flush
    exp_q.push_back(e);                          // Taken on the coming edge
    @(negedge g_clk);
    i_s2_valid = 1'b0;
endtask

// Start a multiply, then abort it mid-run
task automatic flush_mul(input s2_op_t op);
    i_s2_op    = op;
    i_s2_valid = 1'b1;
    repeat (3) @(negedge g_clk);
    i_flush = 1'b1;
    #(PERIOD/4);
    assert (o_s2_busy)
        else begin
            other_errors++;
            $display("multiply had already finished when the flush was issued");
        end
    @(negedge g_clk);
    i_flush    = 1'b0;
    i_s2_valid = 1'b0;
    hold_busy  = 1'b0;
endtask

// --------------------
// Monitor, samples a quarter period before each rising edge

always begin
    @(negedge g_clk);
    #(PERIOD/4);
    if (g_resetn) begin
        if (flush_seen) begin
            assert (!o_s3_valid)
                else begin
                    other_errors++;
                    $display("o_s3_valid still high one cycle after a flush");
                end
        end
        if (o_s3_valid && (!i_s3_busy || i_flush)) begin
            check_result();                      // Stalled record checked before the flush
        end
        flush_seen = i_flush;
    end
end

// --------------------
// Main sequence

initial begin
    int          fd;
    int          code;
    int          n;
    string       line;
    logic [31:0] col [11];
    s2_op_t      op;
    exp_t        e;

    g_resetn    = 1'b0;
    i_s2_op     = '0;
    i_s2_valid  = 1'b0;
    i_flush     = 1'b0;
    cycles      = 0;
    cycle_limit = LINE_CYC;
    n           = 0;

    fd = $fopen("verif/exec_stim.txt", "r");
    if (fd == 0) begin
        other_errors++;
        $display("cannot open the stimulus file verif/exec_stim.txt");
    end else begin
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                               col[0], col[1], col[2], col[3], col[4], col[5],
                               col[6], col[7], col[8], col[9], col[10]);
                if (code == 11) begin
                    op       = '0;
                    op.fu    = col[0][4:0];
                    op.uop   = col[1][UOP_W-1:0];
                    op.rd    = col[2][REG_W-1:0];
                    op.opr_a = col[3];
                    op.opr_b = col[4];
                    op.opr_c = col[5];
                    op.trap  = col[6][0];
                    op.size  = 2'b10;            // Word
                    op.instr = n;                // Order tag
                    e.rd     = op.rd;
                    e.uop    = col[8][UOP_W-1:0];
                    e.opr_a  = col[9];
                    e.opr_b  = col[10];
                    e.fu     = op.fu;
                    e.trap   = op.trap;
                    e.size   = op.size;
                    e.tag    = n;
                    ops.push_back(op);
                    exps.push_back(e);
                    flushes.push_back(col[7][0]);
                    n++;
                end else begin
                    other_errors++;
                    $display("malformed stimulus line: %s", line);
                end
            end
        end
        $fclose(fd);
    end
    cycle_limit = LINE_CYC * (ops.size() + 1) + RESET_CYC;

    repeat (RESET_CYC) @(negedge g_clk);
    g_resetn = 1'b1;
    #(PERIOD/4);
    assert (!o_s3_valid && !o_s2_busy)
        else begin
            other_errors++;
            $display("stage not idle after reset");
        end
    @(negedge g_clk);

    for (int i = 0; i < ops.size(); i++) begin
        if (flushes[i]) begin
            flush_mul(ops[i]);
        end else begin
            send_op(ops[i], exps[i], (i + 1 < ops.size()) && flushes[i + 1]);
        end
    end
    while (exp_q.size() != 0) @(negedge g_clk);
    repeat (4) @(negedge g_clk);                 // Catch stray results
    finish_run();
end

endmodule
